// File: bench/tb_vid_out.sv
`timescale 1ns/1ps

module tb_vid_out
  import vid_color_pkg::*, vid_sync_pkg::*;
();

  localparam int    OUT_W     = VGA_BITS_DEFAULT;
  localparam int    BURST     = 160;
  localparam int    LIMIT     = 64;  // Drain timeout in cycles
  localparam sync_t IDLE_SYNC = '{hs: 1'b1, vs: 1'b1, cs: 1'b1, de: 1'b0};

  logic             clk_vid;
  logic             rst_n;
  pixel_t           pix_in;
  osd_t             osd;
  out_cfg_t         cfg;
  logic             vga_hs;
  logic             vga_vs;
  logic [OUT_W-1:0] vga_r;
  logic [OUT_W-1:0] vga_g;
  logic [OUT_W-1:0] vga_b;
  int               error_count;
  int               sampled;
  int               retired;
  integer           seed;
  logic             timed_out;

  initial begin
    clk_vid = 1'b0;
    forever #4 clk_vid = ~clk_vid;
  end

  vid_out_top #(.out_bits(OUT_W)) i_dut (
    .clk_vid (clk_vid), .rst_n (rst_n), .pix_in (pix_in), .osd (osd), .cfg (cfg),
    .vga_hs (vga_hs), .vga_vs (vga_vs), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b)
  );

  vid_out_checker #(.out_bits(OUT_W)) i_chk (
    .clk_vid (clk_vid), .rst_n (rst_n), .pix_in (pix_in), .osd (osd), .cfg (cfg),
    .vga_hs (vga_hs), .vga_vs (vga_vs), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
    .error_count (error_count), .sampled (sampled), .retired (retired)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus, all on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_vid);
      pix_in.sync  = IDLE_SYNC;  // Blanking, syncs inactive
      pix_in.color = '0;
      osd          = '0;
    end
  endtask

  task automatic send_random(input int count, input logic window);
    logic [31:0] word;
    repeat (count) begin
      @(negedge clk_vid);
      word             = $random(seed);
      pix_in.color.rgb = word[23:0];
      pix_in.sync      = {word[26:24], |word[28:27]};  // de high three times in four
      osd              = {window, word[31]};
    end
  endtask

  task automatic set_cfg(input out_cfg_t new_cfg);
    @(negedge clk_vid);
    cfg = new_cfg;
    drive_idle(6);
  endtask

  // Wait until every sampled pixel has reached the outputs
  task automatic drain(input string what);
    int target;
    int waited;
    drive_idle(1);
    target = sampled;
    waited = 0;
    while (retired < target && waited < LIMIT) begin
      @(negedge clk_vid);
      waited++;
    end
    if (retired < target) begin
      $display("Timeout: pipeline did not drain within %0d cycles in %s", LIMIT, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input string name, input out_cfg_t test_cfg, input logic window,
                          input int count);
    if (timed_out)
      return;
    i_chk.begin_test(name);
    set_cfg(test_cfg);
    send_random(count, window);
    drain(name);
    i_chk.end_test();
  endtask

  initial begin
    seed         = 81515;
    timed_out    = 1'b0;
    rst_n        = 1'b0;
    cfg          = '0;
    osd          = '0;
    pix_in.sync  = IDLE_SYNC;
    pix_in.color = '0;
    i_chk.begin_test("reset");
    repeat (2) @(negedge clk_vid);
    rst_n = 1'b1;
    drive_idle(8);
    drain("reset");
    i_chk.end_test();
    run_test("rgb pass-through", '0, 1'b0, BURST);
    run_test("osd overlay", '0, 1'b1, BURST);
    run_test("ypbpr", out_cfg_t'(5'b10000), 1'b0, BURST);
    for (int k = 0; k < 16; k++)  // no_csync, sel_csync, hsync_pol, vsync_pol
      run_test($sformatf("sync select %0d", k), out_cfg_t'({1'b0, 4'(k)}), 1'b0, 24);
    i_chk.print_totals();
    if (timed_out || error_count != 0)
      $display("Simulation failed");
    else
      $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: bench/vid_out_assert.sv
`timescale 1ns/1ps

module vid_out_assert
  import vid_color_pkg::*, vid_sync_pkg::*;
#(
  parameter int out_bits = VGA_BITS_DEFAULT
) (
  input logic                clk_vid,
  input logic                rst_n,
  input out_cfg_t            cfg,
  input logic                de,
  input logic                vga_hs,
  input logic                vga_vs,
  input logic [out_bits-1:0] vga_r,
  input logic [out_bits-1:0] vga_g,
  input logic [out_bits-1:0] vga_b
);

  logic       force_csync;
  logic       blank;
  logic [2:0] csync_run;  // Cycles with csync forced, stops at 5

  assign force_csync = cfg.ypbpr | (~cfg.no_csync & cfg.sel_csync);
  assign blank       = (vga_r == '0) && (vga_g == '0) && (vga_b == '0);

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n)
      csync_run <= '0;
    else if (!force_csync)
      csync_run <= '0;
    else if (csync_run != 3'd5)
      csync_run <= csync_run + 3'd1;
  end

  reset_zero: assert property (@(posedge clk_vid) !rst_n |-> (blank && !vga_hs && !vga_vs))
    else $error("VGA outputs not zero during reset");

  csync_vs_high: assert property (@(posedge clk_vid) disable iff (!rst_n)
                                  csync_run == 3'd5 |-> vga_vs)
    else $error("vga_vs low while composite sync is forced");

  de_blank: assert property (@(posedge clk_vid) disable iff (!rst_n) !$past(de, 5) |-> blank)
    else $error("colours not blanked five cycles after de low");

endmodule

bind vid_out_top vid_out_assert #(.out_bits(out_bits)) i_assert (
  .clk_vid (clk_vid),
  .rst_n   (rst_n),
  .cfg     (cfg),
  .de      (pix_in.sync.de),
  .vga_hs  (vga_hs),
  .vga_vs  (vga_vs),
  .vga_r   (vga_r),
  .vga_g   (vga_g),
  .vga_b   (vga_b)
);

// File: bench/vid_out_checker.sv
`timescale 1ns/1ps

module vid_out_checker
  import vid_color_pkg::*, vid_sync_pkg::*;
#(
  parameter int out_bits = VGA_BITS_DEFAULT
) (
  input  logic                clk_vid,
  input  logic                rst_n,
  input  pixel_t              pix_in,
  input  osd_t                osd,
  input  out_cfg_t            cfg,
  input  logic                vga_hs,
  input  logic                vga_vs,
  input  logic [out_bits-1:0] vga_r,
  input  logic [out_bits-1:0] vga_g,
  input  logic [out_bits-1:0] vga_b,
  output int                  error_count,
  output int                  sampled,
  output int                  retired
);

  localparam int DEPTH  = 5;  // Input to output latency
  localparam int SETTLE = 6;  // Compares skipped after a cfg change

  typedef struct packed {
    pixel_t   pix;
    osd_t     osd;
    out_cfg_t cfg;
  } in_rec_t;

  typedef struct packed {
    logic                hs;
    logic                vs;
    logic [out_bits-1:0] r;
    logic [out_bits-1:0] g;
    logic [out_bits-1:0] b;
  } vga_exp_t;

  in_rec_t  hist [DEPTH];
  out_cfg_t last_cfg;
  int       n_hist       = 0;
  int       quiet        = 0;
  int       err_total    = 0;
  int       chk_total    = 0;
  int       sample_cnt   = 0;
  int       retire_cnt   = 0;
  int       test_num     = 0;
  int       err_base     = 0;
  int       chk_base     = 0;
  int       tests_passed = 0;
  int       tests_failed = 0;
  string    test_name;

  assign error_count = err_total;
  assign sampled     = sample_cnt;
  assign retired     = retire_cnt;

  function automatic logic [7:0] clamp_byte(input int v);
    if (v < 0)
      return 8'd0;
    if (v > 255)
      return 8'd255;
    return v[7:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of the whole output path
  ////////////////////////////////////////////////////////////

  function automatic vga_exp_t expected_vga(input in_rec_t rec);
    vga_exp_t   want;
    logic [7:0] red;
    logic [7:0] grn;
    logic [7:0] blu;
    logic [5:0] osd_col;
    logic [7:0] ch0;
    logic [7:0] ch1;
    logic [7:0] ch2;
    int         ri;
    int         gi;
    int         bi;
    logic       force_cs;
    red = rec.pix.color.rgb.red;
    grn = rec.pix.color.rgb.green;
    blu = rec.pix.color.rgb.blue;
    if (rec.osd.window) begin
      osd_col = rec.osd.pixel ? 6'b11_11_11 : 6'b00_00_10;  // Red, green, blue
      red = {osd_col[5:4], red[7:2]};
      grn = {osd_col[3:2], grn[7:2]};
      blu = {osd_col[1:0], blu[7:2]};
    end
    ri = int'(red);
    gi = int'(grn);
    bi = int'(blu);
    if (rec.cfg.ypbpr) begin
      ch0 = clamp_byte(((128 * ri - 107 * gi - 21 * bi) >>> 8) + 128);  // Pr
      ch1 = clamp_byte((77 * ri + 150 * gi + 29 * bi) >>> 8);           // Y
      ch2 = clamp_byte(((-43 * ri - 85 * gi + 128 * bi) >>> 8) + 128);  // Pb
    end else begin
      ch0 = red;
      ch1 = grn;
      ch2 = blu;
    end
    force_cs = rec.cfg.ypbpr | (~rec.cfg.no_csync & rec.cfg.sel_csync);
    want.hs  = force_cs ? rec.pix.sync.cs : rec.pix.sync.hs ^ rec.cfg.hsync_pol;
    want.vs  = force_cs ? 1'b1 : rec.pix.sync.vs ^ rec.cfg.vsync_pol;
    want.r   = rec.pix.sync.de ? ch0[7 -: out_bits] : '0;
    want.g   = rec.pix.sync.de ? ch1[7 -: out_bits] : '0;
    want.b   = rec.pix.sync.de ? ch2[7 -: out_bits] : '0;
    return want;
  endfunction

  task automatic check_field(input string name, input logic [7:0] want, input logic [7:0] got);
    if (got !== want) begin
      $display("CHECK FAILED %s expected 0x%h got 0x%h at %0t", name, want, got, $time);
      err_total++;
    end
  endtask

  task automatic compare_vga(input vga_exp_t want);
    chk_total++;
    check_field("vga_hs", 8'(want.hs), 8'(vga_hs));
    check_field("vga_vs", 8'(want.vs), 8'(vga_vs));
    check_field("vga_r", 8'(want.r), 8'(vga_r));
    check_field("vga_g", 8'(want.g), 8'(vga_g));
    check_field("vga_b", 8'(want.b), 8'(vga_b));
  endtask

  // Outputs still hold their pre-edge values here
  always @(posedge clk_vid) begin
    if (!rst_n) begin
      compare_vga('0);
      n_hist   = 0;
      quiet    = 0;
      last_cfg = cfg;
    end else begin
      if (cfg != last_cfg)
        quiet = SETTLE;
      last_cfg = cfg;
      if (n_hist < DEPTH) begin
        compare_vga('0);  // Reset contents still in flight
      end else begin
        if (quiet == 0)
          compare_vga(expected_vga(hist[DEPTH-1]));
        retire_cnt++;
      end
      if (quiet != 0)
        quiet--;
      for (int i = DEPTH - 1; i > 0; i--)
        hist[i] = hist[i-1];
      hist[0] = {pix_in, osd, cfg};
      sample_cnt++;
      if (n_hist < DEPTH)
        n_hist++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test bookkeeping
  ////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    test_num++;
    test_name = name;
    err_base  = err_total;
    chk_base  = chk_total;
  endtask

  task automatic end_test();
    int errs;
    errs = err_total - err_base;
    if (errs == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("Test %0d (%s): %s, %0d errors in %0d checks", test_num, test_name,
             (errs == 0) ? "passed" : "FAILED", errs, chk_total - chk_base);
  endtask

  task automatic print_totals();
    $display("Totals: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, chk_total, err_total);
  endtask

endmodule

// File: build.f
hdl/vid_color_pkg.sv
hdl/vid_sync_pkg.sv
hdl/osd_overlay.sv
hdl/rgb_to_ypbpr.sv
hdl/vga_out_stage.sv
hdl/vid_out_top.sv
bench/vid_out_checker.sv
bench/vid_out_assert.sv
bench/tb_vid_out.sv

// File: hdl/osd_overlay.sv
`timescale 1ns/1ps

module osd_overlay
  import vid_color_pkg::*, vid_sync_pkg::*;
(
  input  logic   clk_vid,
  input  logic   rst_n,
  input  pixel_t pix_in,
  input  osd_t   osd,
  output pixel_t ovl_pix
);

  logic [3*OSD_BITS-1:0] osd_color;
  rgb_t                  vid_rgb;
  rgb_t                  mix_rgb;
  pixel_t                mix_pix;

  // OSD bits on top, video shifted down below them
  function automatic chan_t over_chan(input logic [OSD_BITS-1:0] osd_bits,
                                      input chan_t               vid);
    return {osd_bits, vid[CHAN_BITS-1 -: CHAN_BITS-OSD_BITS]};
  endfunction

  assign osd_color = osd.pixel ? OSD_ON_COLOR : OSD_OFF_COLOR;
  assign vid_rgb   = pix_in.color.rgb;

  always_comb begin
    mix_rgb = vid_rgb;
    if (osd.window) begin
      mix_rgb.red   = over_chan(osd_color[3*OSD_BITS-1 -: OSD_BITS], vid_rgb.red);
      mix_rgb.green = over_chan(osd_color[2*OSD_BITS-1 -: OSD_BITS], vid_rgb.green);
      mix_rgb.blue  = over_chan(osd_color[OSD_BITS-1:0], vid_rgb.blue);
    end
  end

  always_comb begin
    mix_pix.sync      = pix_in.sync;
    mix_pix.color.rgb = mix_rgb;
  end

  ////////////////////////////////////////////////////////////
  // Pixel and sync register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      ovl_pix <= '0;
    end else begin
      ovl_pix <= mix_pix;  // Syncs aligned with the merged colour
    end
  end

endmodule

// File: hdl/rgb_to_ypbpr.sv
`timescale 1ns/1ps

module rgb_to_ypbpr
  import vid_color_pkg::*, vid_sync_pkg::*;
(
  input  logic   clk_vid,
  input  logic   rst_n,
  input  logic   ypbpr,
  input  pixel_t pix_in,
  output pixel_t pix_out
);

  // Matrix rows are Y, Pb, Pr and columns are R, G, B
  logic signed [COEF_BITS-1:0] r_s;
  logic signed [COEF_BITS-1:0] g_s;
  logic signed [COEF_BITS-1:0] b_s;
  logic signed [PROD_BITS-1:0] s1_prod [3][3];
  logic signed [SUM_BITS-1:0]  row_sum [3];
  logic signed [ROW_BITS-1:0]  row_val [3];
  logic signed [ROW_BITS-1:0]  s2_row  [3];
  pixel_t                      dly_pix [2];   // Syncs and RGB beside the matrix
  logic                        dly_mode [2];
  ypbpr_t                      conv_word;

  function automatic logic signed [PROD_BITS-1:0] mul(input logic signed [COEF_BITS-1:0] a,
                                                      input logic signed [COEF_BITS-1:0] b);
    return PROD_BITS'(a) * PROD_BITS'(b);
  endfunction

  // Saturate to 0..255
  function automatic chan_t clamp_chan(input logic signed [ROW_BITS-1:0] v);
    if (v[ROW_BITS-1])
      return '0;
    else if (|v[ROW_BITS-2:CHAN_BITS])
      return '1;
    else
      return v[CHAN_BITS-1:0];
  endfunction

  assign r_s = $signed({1'b0, pix_in.color.rgb.red});
  assign g_s = $signed({1'b0, pix_in.color.rgb.green});
  assign b_s = $signed({1'b0, pix_in.color.rgb.blue});

  ////////////////////////////////////////////////////////////
  // Stage 1, products
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
          s1_prod[i][j] <= '0;
    end else begin
      s1_prod[0][0] <= mul(r_s, Y_COEF_R);
      s1_prod[0][1] <= mul(g_s, Y_COEF_G);
      s1_prod[0][2] <= mul(b_s, Y_COEF_B);
      s1_prod[1][0] <= mul(r_s, PB_COEF_R);
      s1_prod[1][1] <= mul(g_s, PB_COEF_G);
      s1_prod[1][2] <= mul(b_s, PB_COEF_B);
      s1_prod[2][0] <= mul(r_s, PR_COEF_R);
      s1_prod[2][1] <= mul(g_s, PR_COEF_G);
      s1_prod[2][2] <= mul(b_s, PR_COEF_B);
    end
  end

  // Row sums, floor divide by 256
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      row_sum[i] = SUM_BITS'(s1_prod[i][0]) + SUM_BITS'(s1_prod[i][1])
                 + SUM_BITS'(s1_prod[i][2]);
      row_val[i] = ROW_BITS'(row_sum[i] >>> COEF_SHIFT);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, sums with chroma offset
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++)
        s2_row[i] <= '0;
    end else begin
      s2_row[0] <= row_val[0];
      s2_row[1] <= row_val[1] + CHROMA_OFFSET;  // Pb
      s2_row[2] <= row_val[2] + CHROMA_OFFSET;  // Pr
    end
  end

  always_comb begin
    conv_word.y  = clamp_chan(s2_row[0]);
    conv_word.pb = clamp_chan(s2_row[1]);
    conv_word.pr = clamp_chan(s2_row[2]);
  end

  // Delay line matching stages 1 and 2
  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      dly_pix[0]  <= '0;
      dly_pix[1]  <= '0;
      dly_mode[0] <= 1'b0;
      dly_mode[1] <= 1'b0;
    end else begin
      dly_pix[0]  <= pix_in;
      dly_pix[1]  <= dly_pix[0];
      dly_mode[0] <= ypbpr;
      dly_mode[1] <= dly_mode[0];
    end
  end

  // Stage 3, clamp or bypass
  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      pix_out <= '0;
    end else begin
      pix_out.sync <= dly_pix[1].sync;
      if (dly_mode[1])
        pix_out.color.ypbpr <= conv_word;
      else
        pix_out.color <= dly_pix[1].color;
    end
  end

endmodule

// File: hdl/vga_out_stage.sv
`timescale 1ns/1ps

module vga_out_stage
  import vid_color_pkg::*, vid_sync_pkg::*;
#(
  parameter int out_bits = VGA_BITS_DEFAULT  // 1 to 8
) (
  input  logic                clk_vid,
  input  logic                rst_n,
  input  out_cfg_t            cfg,
  input  pixel_t              pix_in,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic [out_bits-1:0] vga_r,
  output logic [out_bits-1:0] vga_g,
  output logic [out_bits-1:0] vga_b
);

  logic  force_csync;
  sync_t sync_in;
  rgb_t  rgb_in;

  // YPbPr always wants composite sync on the hsync pin
  assign force_csync = cfg.ypbpr | (~cfg.no_csync & cfg.sel_csync);

  assign sync_in = pix_in.sync;
  assign rgb_in  = pix_in.color.rgb;  // Same bits for either view

  ////////////////////////////////////////////////////////////
  // Sync select and polarity
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      vga_hs <= 1'b0;
      vga_vs <= 1'b0;
    end else if (force_csync) begin
      vga_hs <= sync_in.cs;
      vga_vs <= 1'b1;                  // Vsync unused with csync
    end else begin
      vga_hs <= sync_in.hs ^ cfg.hsync_pol;
      vga_vs <= sync_in.vs ^ cfg.vsync_pol;
    end
  end

  ////////////////////////////////////////////////////////////
  // Blanking and truncation
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end else if (sync_in.de) begin
      vga_r <= rgb_in.red[CHAN_BITS-1 -: out_bits];
      vga_g <= rgb_in.green[CHAN_BITS-1 -: out_bits];
      vga_b <= rgb_in.blue[CHAN_BITS-1 -: out_bits];
    end else begin
      // Black outside the display area
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end
  end

endmodule

// File: hdl/vid_color_pkg.sv
package vid_color_pkg;

  ////////////////////////////////////////////////////////////
  // Channel widths
  ////////////////////////////////////////////////////////////

  localparam int CHAN_BITS        = 8;
  localparam int VGA_BITS_DEFAULT = 6;  // Default VGA DAC width
  localparam int OSD_BITS         = 2;  // Top bits taken over by the OSD

  typedef logic [CHAN_BITS-1:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

  // Pr sits on red, Y on green, Pb on blue
  typedef struct packed {
    chan_t pr;
    chan_t y;
    chan_t pb;
  } ypbpr_t;

  typedef union packed {
    rgb_t   rgb;
    ypbpr_t ypbpr;
  } color_u;

  // OSD colours, red in the top field and blue in the bottom one
  localparam logic [3*OSD_BITS-1:0] OSD_ON_COLOR  = {OSD_BITS'(3), OSD_BITS'(3), OSD_BITS'(3)};
  localparam logic [3*OSD_BITS-1:0] OSD_OFF_COLOR = {OSD_BITS'(0), OSD_BITS'(0), OSD_BITS'(2)};

  ////////////////////////////////////////////////////////////
  // Colour matrix, coefficients scaled by 256
  ////////////////////////////////////////////////////////////

  localparam int COEF_BITS  = CHAN_BITS + 1;     // Signed, also holds a channel
  localparam int COEF_SHIFT = 8;
  localparam int PROD_BITS  = 2 * COEF_BITS;
  localparam int SUM_BITS   = PROD_BITS + 2;     // Three products
  localparam int ROW_BITS   = SUM_BITS - COEF_SHIFT;

  localparam logic signed [COEF_BITS-1:0] Y_COEF_R  = COEF_BITS'(77);
  localparam logic signed [COEF_BITS-1:0] Y_COEF_G  = COEF_BITS'(150);
  localparam logic signed [COEF_BITS-1:0] Y_COEF_B  = COEF_BITS'(29);
  localparam logic signed [COEF_BITS-1:0] PB_COEF_R = COEF_BITS'(-43);
  localparam logic signed [COEF_BITS-1:0] PB_COEF_G = COEF_BITS'(-85);
  localparam logic signed [COEF_BITS-1:0] PB_COEF_B = COEF_BITS'(128);
  localparam logic signed [COEF_BITS-1:0] PR_COEF_R = COEF_BITS'(128);
  localparam logic signed [COEF_BITS-1:0] PR_COEF_G = COEF_BITS'(-107);
  localparam logic signed [COEF_BITS-1:0] PR_COEF_B = COEF_BITS'(-21);

  localparam logic signed [ROW_BITS-1:0] CHROMA_OFFSET = ROW_BITS'(128);

endpackage

// File: hdl/vid_out_top.sv
`timescale 1ns/1ps

module vid_out_top
  import vid_color_pkg::*, vid_sync_pkg::*;
#(
  parameter int out_bits = VGA_BITS_DEFAULT
) (
  input  logic                clk_vid,
  input  logic                rst_n,
  input  pixel_t              pix_in,    // From chipset or RTG
  input  osd_t                osd,
  input  out_cfg_t            cfg,       // Quasi-static
  output logic                vga_hs,
  output logic                vga_vs,
  output logic [out_bits-1:0] vga_r,
  output logic [out_bits-1:0] vga_g,
  output logic [out_bits-1:0] vga_b
);

  pixel_t ovl_pix;   // RGB with OSD merged
  pixel_t conv_pix;  // RGB or YPbPr

  ////////////////////////////////////////////////////////////
  // Five clk_vid cycles from pix_in to the VGA pins
  ////////////////////////////////////////////////////////////

  osd_overlay i_osd (
    .clk_vid (clk_vid),
    .rst_n   (rst_n),
    .pix_in  (pix_in),
    .osd     (osd),
    .ovl_pix (ovl_pix)
  );

  rgb_to_ypbpr i_conv (
    .clk_vid (clk_vid),
    .rst_n   (rst_n),
    .ypbpr   (cfg.ypbpr),
    .pix_in  (ovl_pix),
    .pix_out (conv_pix)
  );

  vga_out_stage #(
    .out_bits (out_bits)
  ) i_vga (
    .clk_vid (clk_vid),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .pix_in  (conv_pix),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
  );

endmodule

// File: hdl/vid_sync_pkg.sv
package vid_sync_pkg;

  // Chipset syncs are active low, de marks the display area
  typedef struct packed {
    logic hs;
    logic vs;
    logic cs;
    logic de;
  } sync_t;

  // One pixel with its syncs
  typedef struct packed {
    sync_t                 sync;
    vid_color_pkg::color_u color;
  } pixel_t;

  typedef struct packed {
    logic window;  // OSD area
    logic pixel;   // OSD foreground
  } osd_t;

  ////////////////////////////////////////////////////////////
  // Output configuration from the core menu
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic ypbpr;
    logic no_csync;
    logic sel_csync;
    logic hsync_pol;
    logic vsync_pol;
  } out_cfg_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile and run the video output testbench with Verilator

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_vid_out -f build.f \
    --Mdir obj_dir -o vsim; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/vsim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation run returned an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Simulation completed successfully" "$LOG"; then
  echo "No pass message found in $LOG"
  exit 1
fi

exit 0
